//--- verilog/rv32i_types_pkg.sv
//------------------------------
// rv32i instruction encodings
// opcodes, funct3 codes and the
// packed views of one word
//------------------------------
package rv32i_types_pkg;

  typedef logic [31:0] word_t;

  // major opcodes in bits [6:0]
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct3_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } reg_funct3_t;

  // 3'b100 is unused in the system space
  typedef enum logic [2:0] {
    PRIV   = 3'b000,
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } system_funct3_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

endpackage

//--- verilog/dispatch_types_pkg.sv
//------------------------------
// dispatch side types
// fetch packet, decoded record
// and decoder output encodings
//------------------------------
package dispatch_types_pkg;

  // word tagged with its pc
  typedef struct packed {
    rv32i_types_pkg::word_t pc;
    rv32i_types_pkg::word_t instr;
  } fetch_pkt_t;

  // functional unit select
  typedef enum logic [1:0] {
    ARITH_S     = 2'd0,
    MUL_S       = 2'd1,
    DIV_S       = 2'd2,
    LOADSTORE_S = 2'd3
  } sfu_type_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // register write-back source
  typedef enum logic [2:0] {
    LOAD_SRC = 3'd0,
    JUMP_SRC = 3'd1,
    LUI_SRC  = 3'd2,
    ALU_SRC  = 3'd3,
    CSR_SRC  = 3'd4
  } w_src_t;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_SWAP = 2'd1,
    CSR_SET  = 2'd2,
    CSR_CLR  = 2'd3
  } csr_op_t;

  typedef struct packed {
    rv32i_types_pkg::word_t   pc;
    rv32i_types_pkg::word_t   imm;
    rv32i_types_pkg::opcode_t opcode;
    sfu_type_t                sfu_type;
    alu_op_t                  alu_op;
    w_src_t                   w_src;
    csr_op_t                  csr_op;
    logic                     csr_imm;
    logic [4:0]               rd;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic                     wen;
    logic                     branch;
    logic                     jump;
    logic                     illegal;
    logic                     halt;
  } decoded_instr_t;

endpackage

//--- verilog/fetch_issuer.sv
//------------------------------
// fetch issuer
// tags incoming words with a pc
// and pushes them on credits
//------------------------------
module fetch_issuer #(
  parameter int                     QUEUE_DEPTH = 4,
  parameter rv32i_types_pkg::word_t RESET_PC    = 32'h0000_0200
) (
  input  logic                           CLK,
  input  logic                           reset_i,
  input  rv32i_types_pkg::word_t         instr_i,
  input  logic                           instr_valid_i,
  input  logic                           credit_return_i,
  output logic                           instr_ready_o,
  output dispatch_types_pkg::fetch_pkt_t push_pkt_o,
  output logic                           push_valid_o
);
  import rv32i_types_pkg::*;

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [CNT_W-1:0] credit_cnt;
  word_t            pc_q;
  logic             accept;

  // one credit per free queue slot
  assign instr_ready_o = (credit_cnt != '0);
  assign accept        = instr_valid_i && instr_ready_o;

  // push goes out in the accept cycle
  assign push_valid_o     = accept;
  assign push_pkt_o.pc    = pc_q;
  assign push_pkt_o.instr = instr_i;

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      credit_cnt <= CNT_W'(QUEUE_DEPTH);
      pc_q       <= RESET_PC;
    end else begin
      case ({accept, credit_return_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      if (accept) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // queue must never hand back more credits than it has slots
  a_credit_bound: assert property (@(posedge CLK) disable iff (reset_i)
    credit_cnt <= CNT_W'(QUEUE_DEPTH))
    else $error("credit count 0x%0h above queue depth", credit_cnt);

endmodule

//--- verilog/instr_queue.sv
//------------------------------
// instruction queue
// circular buffer of fetch
// packets, one credit per pop
//------------------------------
module instr_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                           CLK,
  input  logic                           reset_i,
  input  dispatch_types_pkg::fetch_pkt_t push_pkt_i,
  input  logic                           push_valid_i,
  input  logic                           pop_i,
  output dispatch_types_pkg::fetch_pkt_t head_pkt_o,
  output logic                           head_valid_o,
  output logic                           credit_return_o
);
  import dispatch_types_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  fetch_pkt_t       mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;

  assign full  = (count == CNT_W'(QUEUE_DEPTH));
  assign empty = (count == '0);

  assign head_pkt_o      = mem[rd_ptr];
  assign head_valid_o    = !empty;
  assign credit_return_o = pop_i;

  // payload storage
  always_ff @(posedge CLK) begin
    if (push_valid_i) begin
      mem[wr_ptr] <= push_pkt_i;
    end
  end

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge CLK) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_valid_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_valid_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // issuer credits keep pushes in bounds
  a_no_overflow: assert property (@(posedge CLK) disable iff (reset_i)
    push_valid_i |-> !full)
    else $error("push into full queue");

  a_no_underflow: assert property (@(posedge CLK) disable iff (reset_i)
    pop_i |-> !empty)
    else $error("pop from empty queue");

endmodule

//--- verilog/control_unit.sv
//------------------------------
// control unit
// decodes the queue head and
// holds the dispatch record
//------------------------------
module control_unit (
  input  logic                               CLK,
  input  logic                               reset_i,
  input  dispatch_types_pkg::fetch_pkt_t     head_pkt_i,
  input  logic                               head_valid_i,
  input  logic                               dispatch_ready_i,
  output logic                               pop_o,
  output dispatch_types_pkg::decoded_instr_t dispatch_o,
  output logic                               dispatch_valid_o
);
  import rv32i_types_pkg::*;
  import dispatch_types_pkg::*;

  word_t          instr;
  itype_t         instr_i;
  stype_t         instr_s;
  rtype_t         instr_r;
  sbtype_t        instr_sb;
  utype_t         instr_u;
  ujtype_t        instr_uj;
  opcode_t        opcode;
  decoded_instr_t dec;
  logic           is_imm;
  logic           is_reg;
  logic           sr;
  logic           add_sub;

  // views of the same word
  assign instr    = head_pkt_i.instr;
  assign instr_i  = itype_t'(instr);
  assign instr_s  = stype_t'(instr);
  assign instr_r  = rtype_t'(instr);
  assign instr_sb = sbtype_t'(instr);
  assign instr_u  = utype_t'(instr);
  assign instr_uj = ujtype_t'(instr);
  assign opcode   = opcode_t'(instr[6:0]);

  assign is_imm  = (opcode == IMMED);
  assign is_reg  = (opcode == REGREG);
  assign sr      = (is_imm && instr_i.funct3 == SRI) || (is_reg && instr_r.funct3 == SR);
  assign add_sub = is_reg && (instr_r.funct3 == ADDSUB);

  always_comb begin
    dec         = '0;
    dec.pc      = head_pkt_i.pc;
    dec.opcode  = opcode;
    dec.rd      = instr[11:7];
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.branch  = (opcode == BRANCH);
    dec.jump    = (opcode == JAL) || (opcode == JALR);
    // jump-to-self is the halt marker
    dec.halt    = (instr == 32'h0000_006f);

    // immediate by format
    case (opcode)
      IMMED, LOAD, JALR, SYSTEM, MISCMEM:
        dec.imm = {{20{instr_i.imm11_00[11]}}, instr_i.imm11_00};
      STORE:
        dec.imm = {{20{instr_s.imm11_05[6]}}, instr_s.imm11_05, instr_s.imm04_00};
      BRANCH:
        dec.imm = {{19{instr_sb.imm12}}, instr_sb.imm12, instr_sb.imm11,
                   instr_sb.imm10_05, instr_sb.imm04_01, 1'b0};
      LUI, AUIPC:
        dec.imm = {instr_u.imm31_12, 12'b0};
      JAL:
        dec.imm = {{11{instr_uj.imm20}}, instr_uj.imm20, instr_uj.imm19_12,
                   instr_uj.imm11, instr_uj.imm10_01, 1'b0};
      default:
        dec.imm = '0;
    endcase

    // functional unit with the m extension on funct7 of one
    if (is_reg && instr_r.funct7 == 7'b000_0001) begin
      dec.sfu_type = instr_r.funct3[2] ? DIV_S : MUL_S;
    end else if (opcode == LOAD || opcode == STORE) begin
      dec.sfu_type = LOADSTORE_S;
    end else begin
      dec.sfu_type = ARITH_S;
    end

    // alu op by first match
    if ((is_imm && instr_i.funct3 == SLLI) || (is_reg && instr_r.funct3 == SLL))
      dec.alu_op = ALU_SLL;
    else if (sr && instr[30])
      dec.alu_op = ALU_SRA;
    else if (sr)
      dec.alu_op = ALU_SRL;
    else if ((is_imm && instr_i.funct3 == ADDI) || opcode == AUIPC ||
             (add_sub && !instr[30]) || opcode == LOAD || opcode == STORE)
      dec.alu_op = ALU_ADD;
    else if (add_sub)
      dec.alu_op = ALU_SUB;
    else if ((is_imm && instr_i.funct3 == ANDI) || (is_reg && instr_r.funct3 == AND))
      dec.alu_op = ALU_AND;
    else if ((is_imm && instr_i.funct3 == ORI) || (is_reg && instr_r.funct3 == OR))
      dec.alu_op = ALU_OR;
    else if ((is_imm && instr_i.funct3 == XORI) || (is_reg && instr_r.funct3 == XOR))
      dec.alu_op = ALU_XOR;
    else if ((is_imm && instr_i.funct3 == SLTI) || (is_reg && instr_r.funct3 == SLT))
      dec.alu_op = ALU_SLT;
    else if ((is_imm && instr_i.funct3 == SLTIU) || (is_reg && instr_r.funct3 == SLTU))
      dec.alu_op = ALU_SLTU;
    else
      dec.alu_op = ALU_ADD;

    // csr op and immediate form
    if (opcode == SYSTEM) begin
      case (instr_i.funct3)
        CSRRW, CSRRWI: dec.csr_op = CSR_SWAP;
        CSRRS, CSRRSI: dec.csr_op = CSR_SET;
        CSRRC, CSRRCI: dec.csr_op = CSR_CLR;
        default:       dec.csr_op = CSR_NONE;
      endcase
      dec.csr_imm = instr_i.funct3[2] && (dec.csr_op != CSR_NONE);
    end

    case (opcode)
      LOAD:                  dec.w_src = LOAD_SRC;
      JAL, JALR:             dec.w_src = JUMP_SRC;
      LUI:                   dec.w_src = LUI_SRC;
      IMMED, AUIPC, REGREG:  dec.w_src = ALU_SRC;
      SYSTEM:                dec.w_src = CSR_SRC;
      default:               dec.w_src = LOAD_SRC;
    endcase

    case (opcode)
      IMMED, LUI, AUIPC, REGREG, JAL, JALR, LOAD: dec.wen = 1'b1;
      SYSTEM:  dec.wen = (dec.csr_op != CSR_NONE);
      default: dec.wen = 1'b0;
    endcase

    // illegal on unknown opcodes and on odd funct7 other than the m extension
    case (opcode)
      REGREG: dec.illegal = instr_r.funct7[0] && (instr_r.funct7 != 7'b000_0001);
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, IMMED, SYSTEM, MISCMEM:
        dec.illegal = 1'b0;
      default: dec.illegal = 1'b1;
    endcase
  end

  // take the head when the output slot is free or draining
  assign pop_o = head_valid_i && (!dispatch_valid_o || dispatch_ready_i);

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      dispatch_valid_o <= 1'b0;
    end else if (pop_o) begin
      dispatch_valid_o <= 1'b1;
    end else if (dispatch_ready_i) begin
      dispatch_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (pop_o) begin
      dispatch_o <= dec;
    end
  end

  a_hold_on_stall: assert property (@(posedge CLK) disable iff (reset_i)
    dispatch_valid_o && !dispatch_ready_i |=> dispatch_valid_o && $stable(dispatch_o))
    else $error("dispatch record changed under stall");

endmodule

//--- verilog/decode_frontend.sv
//------------------------------
// decode front end top level
// issuer, queue, control unit
//------------------------------
module decode_frontend #(
  parameter int                     QUEUE_DEPTH = 4,
  parameter rv32i_types_pkg::word_t RESET_PC    = 32'h0000_0200
) (
  input  logic                               CLK,
  input  logic                               reset_i,
  input  rv32i_types_pkg::word_t             instr_i,
  input  logic                               instr_valid_i,
  output logic                               instr_ready_o,
  output dispatch_types_pkg::decoded_instr_t dispatch_o,
  output logic                               dispatch_valid_o,
  input  logic                               dispatch_ready_i
);
  import dispatch_types_pkg::*;

  fetch_pkt_t push_pkt;
  fetch_pkt_t head_pkt;
  logic       push_valid;
  logic       head_valid;
  logic       pop;
  logic       credit_return;

  fetch_issuer #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .RESET_PC    (RESET_PC)
  ) u_fetch_issuer (
    .CLK             (CLK),
    .reset_i         (reset_i),
    .instr_i         (instr_i),
    .instr_valid_i   (instr_valid_i),
    .credit_return_i (credit_return),
    .instr_ready_o   (instr_ready_o),
    .push_pkt_o      (push_pkt),
    .push_valid_o    (push_valid)
  );

  instr_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_instr_queue (
    .CLK             (CLK),
    .reset_i         (reset_i),
    .push_pkt_i      (push_pkt),
    .push_valid_i    (push_valid),
    .pop_i           (pop),
    .head_pkt_o      (head_pkt),
    .head_valid_o    (head_valid),
    .credit_return_o (credit_return)
  );

  control_unit u_control_unit (
    .CLK              (CLK),
    .reset_i          (reset_i),
    .head_pkt_i       (head_pkt),
    .head_valid_i     (head_valid),
    .dispatch_ready_i (dispatch_ready_i),
    .pop_o            (pop),
    .dispatch_o       (dispatch_o),
    .dispatch_valid_o (dispatch_valid_o)
  );

endmodule

//--- verif/decode_frontend_tb.sv
//------------------------------
// decode front end testbench
// random words in, records out
// checked against a reference
//------------------------------
module decode_frontend_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv32i_types_pkg::*;
  import dispatch_types_pkg::*;

  localparam int    QUEUE_DEPTH = 4;
  localparam word_t RESET_PC    = 32'h0000_0200;
  localparam int    CLK_PERIOD  = 40;
  localparam int    NUM_WORDS   = 2000;
  localparam int    STALL_START = 300;
  localparam int    STALL_LEN   = 40;

  logic           CLK = 1'b0;
  logic           reset_i;
  word_t          instr_i;
  logic           instr_valid_i;
  logic           instr_ready_o;
  decoded_instr_t dispatch_o;
  logic           dispatch_valid_o;
  logic           dispatch_ready_i;

  fetch_pkt_t  sb [$];
  word_t       next_pc = RESET_PC;
  int          errors = 0;
  int          n_accepted = 0;
  int          n_dispatched = 0;
  int          peak = 0;
  int          cyc;
  logic [31:0] rng;
  logic [31:0] sel;
  logic [31:0] body;

  decode_frontend #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .RESET_PC    (RESET_PC)
  ) u_decode_frontend (
    .CLK              (CLK),
    .reset_i          (reset_i),
    .instr_i          (instr_i),
    .instr_valid_i    (instr_valid_i),
    .instr_ready_o    (instr_ready_o),
    .dispatch_o       (dispatch_o),
    .dispatch_valid_o (dispatch_valid_o),
    .dispatch_ready_i (dispatch_ready_i)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // mostly legal opcodes with some raw words and the halt word
  function automatic word_t make_word(input logic [31:0] s, input logic [31:0] b);
    opcode_t    op;
    logic [6:0] f7;
    op = IMMED;
    case (s[5:4])
      2'd0:    f7 = 7'h00;
      2'd1:    f7 = 7'h20;
      2'd2:    f7 = 7'h01;
      default: f7 = b[31:25] | 7'h01;
    endcase
    case (s[3:0])
      4'd0:  op = LUI;
      4'd1:  op = AUIPC;
      4'd2:  op = JAL;
      4'd3:  op = JALR;
      4'd4:  op = BRANCH;
      4'd5:  op = LOAD;
      4'd6:  op = STORE;
      4'd9,
      4'd10: op = REGREG;
      4'd11: op = MISCMEM;
      4'd12,
      4'd13: op = SYSTEM;
      4'd14: return 32'h0000_006f;
      4'd15: return b;
      default: op = IMMED;
    endcase
    if (op == REGREG)
      return {f7, b[24:7], op};
    return {b[31:7], op};
  endfunction

  // immediate and register forms share the funct3 encodings
  function automatic alu_op_t ref_alu_op(input logic [2:0] f3, input logic bit30,
                                         input logic is_reg);
    alu_op_t op;
    case (reg_funct3_t'(f3))
      ADDSUB:
        if (is_reg && bit30)
          op = ALU_SUB;
        else
          op = ALU_ADD;
      SLL:  op = ALU_SLL;
      SLT:  op = ALU_SLT;
      SLTU: op = ALU_SLTU;
      XOR:  op = ALU_XOR;
      SR:
        if (bit30)
          op = ALU_SRA;
        else
          op = ALU_SRL;
      OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  function automatic decoded_instr_t ref_decode(input word_t pc, input word_t w);
    decoded_instr_t d;
    logic [6:0]     f7;
    logic [2:0]     f3;
    word_t          imm_i;
    word_t          imm_s;
    word_t          imm_b;
    word_t          imm_j;
    d     = '0;
    f7    = w[31:25];
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    d.pc     = pc;
    d.opcode = opcode_t'(w[6:0]);
    d.rd     = w[11:7];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.halt   = (w == 32'h0000_006f);
    case (d.opcode)
      LUI: begin
        d.imm   = {w[31:12], 12'b0};
        d.w_src = LUI_SRC;
        d.wen   = 1'b1;
      end
      AUIPC: begin
        d.imm   = {w[31:12], 12'b0};
        d.w_src = ALU_SRC;
        d.wen   = 1'b1;
      end
      JAL, JALR: begin
        d.imm   = (d.opcode == JAL) ? imm_j : imm_i;
        d.jump  = 1'b1;
        d.w_src = JUMP_SRC;
        d.wen   = 1'b1;
      end
      BRANCH: begin
        d.imm    = imm_b;
        d.branch = 1'b1;
      end
      LOAD, STORE: begin
        d.imm      = (d.opcode == LOAD) ? imm_i : imm_s;
        d.sfu_type = LOADSTORE_S;
        d.wen      = (d.opcode == LOAD);
      end
      IMMED, REGREG: begin
        d.imm    = (d.opcode == IMMED) ? imm_i : 32'h0;
        d.alu_op = ref_alu_op(f3, w[30], d.opcode == REGREG);
        d.w_src  = ALU_SRC;
        d.wen    = 1'b1;
        if (d.opcode == REGREG && f7 == 7'h01) begin
          if (f3[2])
            d.sfu_type = DIV_S;
          else
            d.sfu_type = MUL_S;
        end
        d.illegal = (d.opcode == REGREG) && f7[0] && (f7 != 7'h01);
      end
      MISCMEM: d.imm = imm_i;
      SYSTEM: begin
        d.imm   = imm_i;
        d.w_src = CSR_SRC;
        case (system_funct3_t'(f3))
          CSRRW, CSRRWI: d.csr_op = CSR_SWAP;
          CSRRS, CSRRSI: d.csr_op = CSR_SET;
          CSRRC, CSRRCI: d.csr_op = CSR_CLR;
          default:       d.csr_op = CSR_NONE;
        endcase
        d.wen     = (d.csr_op != CSR_NONE);
        d.csr_imm = f3[2] && d.wen;
      end
      default: d.illegal = 1'b1;
    endcase
    return d;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic compare_record(input decoded_instr_t got, input decoded_instr_t exp);
    check_field("dispatch_o.pc", got.pc, exp.pc);
    check_field("dispatch_o.imm", got.imm, exp.imm);
    check_field("dispatch_o.opcode", 32'(got.opcode), 32'(exp.opcode));
    check_field("dispatch_o.sfu_type", 32'(got.sfu_type), 32'(exp.sfu_type));
    check_field("dispatch_o.alu_op", 32'(got.alu_op), 32'(exp.alu_op));
    check_field("dispatch_o.w_src", 32'(got.w_src), 32'(exp.w_src));
    check_field("dispatch_o.csr_op", 32'(got.csr_op), 32'(exp.csr_op));
    check_field("dispatch_o.csr_imm", 32'(got.csr_imm), 32'(exp.csr_imm));
    check_field("dispatch_o.rd", 32'(got.rd), 32'(exp.rd));
    check_field("dispatch_o.rs1", 32'(got.rs1), 32'(exp.rs1));
    check_field("dispatch_o.rs2", 32'(got.rs2), 32'(exp.rs2));
    check_field("dispatch_o.wen", 32'(got.wen), 32'(exp.wen));
    check_field("dispatch_o.branch", 32'(got.branch), 32'(exp.branch));
    check_field("dispatch_o.jump", 32'(got.jump), 32'(exp.jump));
    check_field("dispatch_o.illegal", 32'(got.illegal), 32'(exp.illegal));
    check_field("dispatch_o.halt", 32'(got.halt), 32'(exp.halt));
  endtask

  // output record must hold while the consumer stalls
  stall_hold: assert property (@(posedge CLK) disable iff (reset_i)
    dispatch_valid_o && !dispatch_ready_i |=> dispatch_valid_o && $stable(dispatch_o))
    else begin
      errors++;
      $display("dispatch record changed or dropped while dispatch_ready_i was low");
    end

  // scoreboard sampled at the rising edge
  always @(posedge CLK) begin
    fetch_pkt_t pkt;
    if (!reset_i) begin
      if (sb.size() > peak)
        peak = sb.size();
      assert (sb.size() <= QUEUE_DEPTH + 1) else begin
        errors++;
        $display("more words in flight than the queue and output register can hold");
      end
      if (sb.size() == QUEUE_DEPTH + 1) begin
        assert (!instr_ready_o) else begin
          errors++;
          $display("FAIL instr_ready_o got 0x1 expected 0x0 with pipeline full");
        end
      end
      // fewer words outstanding than slots leaves at least one credit
      if (sb.size() < QUEUE_DEPTH) begin
        assert (instr_ready_o) else begin
          errors++;
          $display("FAIL instr_ready_o got 0x0 expected 0x1 with free queue slots");
        end
      end
      if (dispatch_valid_o && dispatch_ready_i) begin
        if (sb.size() == 0) begin
          errors++;
          $display("record dispatched with no accepted word outstanding");
        end else begin
          pkt = sb.pop_front();
          compare_record(dispatch_o, ref_decode(pkt.pc, pkt.instr));
          n_dispatched++;
        end
      end
      if (instr_valid_i && instr_ready_o) begin
        pkt.pc    = next_pc;
        pkt.instr = instr_i;
        sb.push_back(pkt);
        next_pc = next_pc + 32'd4;
        n_accepted++;
      end
    end
  end

  initial begin
    rng              = 32'h93b1_37e5;
    reset_i          = 1'b1;
    instr_i          = '0;
    instr_valid_i    = 1'b0;
    dispatch_ready_i = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    reset_i = 1'b0;
    assert (instr_ready_o && !dispatch_valid_o) else begin
      errors++;
      $display("front end not idle with credits available after reset");
    end
    cyc = 0;
    while (n_dispatched < NUM_WORDS) begin
      rng  = xorshift(rng);
      sel  = rng;
      rng  = xorshift(rng);
      body = rng;
      // a stretch of full back-pressure with words offered every cycle
      if (cyc >= STALL_START && cyc < STALL_START + STALL_LEN) begin
        instr_valid_i    = 1'b1;
        dispatch_ready_i = 1'b0;
      end else begin
        instr_valid_i    = (sel[8:7] != 2'd0);
        dispatch_ready_i = (sel[10:9] != 2'd0);
      end
      if (n_accepted >= NUM_WORDS)
        instr_valid_i = 1'b0;
      instr_i = make_word(sel, body);
      @(negedge CLK);
      cyc++;
    end
    instr_valid_i    = 1'b0;
    dispatch_ready_i = 1'b1;
    repeat (2) @(negedge CLK);
    assert (peak == QUEUE_DEPTH + 1) else begin
      errors++;
      $display("back-pressure never filled the queue and output register");
    end
    $display("%0d words accepted, %0d records checked, %0d errors",
             n_accepted, n_dispatched, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    #(NUM_WORDS * CLK_PERIOD * 4);
    $display("timeout after %0d records, dispatch never completed", n_dispatched);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- sources.f
verilog/rv32i_types_pkg.sv
verilog/dispatch_types_pkg.sv
verilog/fetch_issuer.sv
verilog/instr_queue.sv
verilog/control_unit.sv
verilog/decode_frontend.sv
verif/decode_frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode front end testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module decode_frontend_tb -f sources.f -o sim_decode_frontend

./obj_dir/sim_decode_frontend | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
